// File: biquad_top.f
rtl/biquad_pkg.sv
rtl/biquad_coeff_if.sv
rtl/biquad_ctrl_regs.sv
rtl/biquad_zero_fir.sv
rtl/biquad_pole_iir.sv
rtl/biquad_top.sv
test/tb_biquad_top.sv

// File: Makefile
VERILATOR    := verilator
TB_TOP       := tb_biquad_top
RTL_TOP      := biquad_top
FILELIST     := biquad_top.f
OBJ_DIR      := obj_dir
LOG          := sim.log
PASS_MSG     := Simulation completed successfully
COMMON_FLAGS := --timing --timescale 1ns/10ps
LINT_FLAGS   := --lint-only $(COMMON_FLAGS)
BUILD_FLAGS  := --binary -j 0 $(COMMON_FLAGS) --Mdir $(OBJ_DIR)
SOURCES      := $(shell cat $(FILELIST))

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

build: $(OBJ_DIR)/V$(TB_TOP)

$(OBJ_DIR)/V$(TB_TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TB_TOP) -f $(FILELIST)

sim: build
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: test/tb_biquad_top.sv
`timescale 1ns/10ps

module tb_biquad_top;

    localparam int CLK_PERIOD = 20;
    localparam int DATA_BITS  = 16;
    // fixed-point rule of the filter with Q4.14 coefficients
    localparam int FRAC  = 14;
    localparam int STATE = 24;
    localparam int ACC   = 40;
    localparam longint SAT_MAX = (longint'(1) <<< (DATA_BITS - 1)) - 1;
    localparam longint SAT_MIN = -(longint'(1) <<< (DATA_BITS - 1));
    localparam logic [6:0] ADR_CTRL = 7'h00;
    localparam int SEED = 54;

    // samples over all tests, for the watchdog
    localparam int NUM_SAMPLES = 8 + 8 + 16 + 200 + 16 + 16 + 32;
    localparam int NUM_WB      = 40;
    localparam int WATCHDOG_NS = CLK_PERIOD * (20 * (NUM_SAMPLES + NUM_WB) + 500);

    logic              clk_i;
    logic              rst_i;
    logic              wb_cyc_i;
    logic              wb_stb_i;
    logic              wb_we_i;
    logic [6:0]        wb_adr_i;
    logic [3:0]        wb_sel_i;
    logic [31:0]       wb_dat_i;
    logic [31:0]       wb_dat_o;
    logic              wb_ack_o;
    logic signed [15:0] dat_i;
    logic              dat_valid_i;
    logic signed [15:0] dat_o;
    logic              dat_valid_o;
    logic              notch_update_i;
    logic [5:0]        notch_byp_i;

    // model state with coefficients in the order b0 b1 b2 a1 a2
    longint m_x1;
    longint m_x2;
    longint m_y1;
    longint m_y2;
    longint m_c [5];
    longint shadow_c [5];
    bit     m_bypass;

    longint      expected_q [$];
    string       test_name;
    logic [31:0] rd;

    biquad_top #(.DATA_BITS(DATA_BITS)) i_biquad_top (.*);

    initial begin : clock_gen
        clk_i = 1'b0;
        forever begin
            #(CLK_PERIOD / 2);
            clk_i = ~clk_i;
        end
    end

    function automatic longint wrap(input longint v, input int bits);
        return (v <<< (64 - bits)) >>> (64 - bits);
    endfunction

    function automatic longint model_step(input longint x);
        longint w;
        longint fb;
        longint y;
        longint out;
        w  = wrap(wrap(m_c[0] * x + m_c[1] * m_x1 + m_c[2] * m_x2, ACC) >>> FRAC, STATE);
        fb = wrap(m_c[3] * m_y1 + m_c[4] * m_y2, ACC);
        y  = wrap(w + wrap(fb >>> FRAC, STATE), STATE);
        if (m_bypass) begin
            out = x;
        end else if (y > SAT_MAX) begin
            out = SAT_MAX;
        end else if (y < SAT_MIN) begin
            out = SAT_MIN;
        end else begin
            out = y;
        end
        // history runs on in bypass too
        m_x2 = m_x1;
        m_x1 = x;
        m_y2 = m_y1;
        m_y1 = y;
        return out;
    endfunction

    task automatic check_value(input string name, input longint expected, input longint actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    task automatic wb_write(input logic [6:0] adr, input logic [31:0] data,
                            input logic [3:0] sel);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = 1'b1;
        wb_adr_i = adr;
        wb_dat_i = data;
        wb_sel_i = sel;
        do idle_cycles(1); while (!wb_ack_o);
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic wb_read(input logic [6:0] adr, output logic [31:0] data);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = 1'b0;
        wb_adr_i = adr;
        do idle_cycles(1); while (!wb_ack_o);
        data     = wb_dat_o;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
    endtask

    task automatic send_sample(input longint x);
        dat_i       = 16'(x);
        dat_valid_i = 1'b1;
        expected_q.push_back(model_step(x));
        idle_cycles(1);
        dat_valid_i = 1'b0;
    endtask

    task automatic send_random(input int n, input int max_gap);
        for (int i = 0; i < n; i++) begin
            send_sample(longint'($urandom_range(65535)) - 32768);
            idle_cycles($urandom_range(max_gap));
        end
    endtask

    task automatic wait_drain();
        while (expected_q.size() != 0) begin
            idle_cycles(1);
        end
        idle_cycles(2);
    endtask

    task automatic write_coeffs();
        for (int i = 0; i < 5; i++) begin
            wb_write(7'(4 + 4 * i), 32'(shadow_c[i]), 4'h1);
        end
    endtask

    // the whole shadow bank goes live one edge after the ack
    task automatic issue_update();
        wb_write(ADR_CTRL, 32'h1, 4'h1);
        m_c = shadow_c;
        idle_cycles(2);
    endtask

    task automatic pulse_notch(input logic [5:0] byp);
        notch_byp_i    = byp;
        notch_update_i = 1'b1;
        idle_cycles(1);
        notch_update_i = 1'b0;
        idle_cycles(3);
    endtask

    initial begin : compare_outputs
        forever begin
            @(negedge clk_i);
            if (dat_valid_o) begin
                if (expected_q.size() == 0) begin
                    $display("dat_valid_o was high with no sample pending in %s", test_name);
                    $display("Simulation failed");
                    $fatal(1, "unexpected output");
                end else begin
                    check_value(test_name, expected_q.pop_front(), longint'(dat_o));
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: the test sequence did not finish within %0d ns", WATCHDOG_NS);
        $display("Simulation failed");
        $fatal(1, "timeout");
    end

    initial begin : test_sequence
        void'($urandom(SEED));
        rst_i          = 1'b1;
        wb_cyc_i       = 1'b0;
        wb_stb_i       = 1'b0;
        wb_we_i        = 1'b0;
        wb_adr_i       = '0;
        wb_sel_i       = '0;
        wb_dat_i       = '0;
        dat_i          = '0;
        dat_valid_i    = 1'b0;
        notch_update_i = 1'b0;
        notch_byp_i    = '0;
        m_x1 = 0;
        m_x2 = 0;
        m_y1 = 0;
        m_y2 = 0;
        m_c  = '{0, 0, 0, 0, 0};
        m_bypass = 1'b1;
        repeat (2) @(posedge clk_i);
        #1;
        rst_i = 1'b0;

        test_name = "reset_defaults";
        wb_read(ADR_CTRL, rd);
        check_value("reset_ctrl", longint'(32'h0001_0000), longint'(rd));
        for (int i = 0; i < 5; i++) begin
            wb_read(7'(4 + 4 * i), rd);
            check_value("reset_coeff", 0, longint'(rd));
        end
        send_random(8, 2);
        wait_drain();

        // shadow writes alone leave the active set at zero
        test_name = "shadow_active";
        shadow_c = '{8192, 4096, 2048, 6144, -4096};
        write_coeffs();
        for (int i = 0; i < 5; i++) begin
            wb_read(7'(4 + 4 * i), rd);
            check_value("shadow_readback", shadow_c[i], longint'($signed(rd)));
        end
        wb_write(ADR_CTRL, 32'h0, 4'b0100);
        m_bypass = 1'b0;
        send_random(8, 1);
        wait_drain();
        issue_update();
        send_sample(16000);
        for (int i = 0; i < 15; i++) begin
            send_sample(0);
        end
        wait_drain();

        test_name = "random_stream";
        for (int i = 0; i < 3; i++) begin
            shadow_c[i] = longint'($urandom_range(16383)) - 8192;
        end
        shadow_c[3] = longint'($urandom_range(12000)) - 6000;
        shadow_c[4] = longint'($urandom_range(12000)) - 6000;
        write_coeffs();
        issue_update();
        send_random(200, 3);
        wait_drain();

        // gain of two on full-scale input drives the clamp
        test_name = "saturation";
        shadow_c = '{32768, 0, 0, 0, 0};
        write_coeffs();
        issue_update();
        for (int i = 0; i < 8; i++) begin
            send_sample((i % 2 == 0) ? SAT_MAX : SAT_MIN);
        end
        send_random(8, 1);
        wait_drain();

        test_name = "notch_bypass";
        shadow_c = '{8192, 4096, 2048, 6144, -4096};
        write_coeffs();
        issue_update();
        wb_write(ADR_CTRL, 32'h0500_0000, 4'b1000);
        pulse_notch(6'b000100);
        m_bypass = 1'b1;
        wb_read(ADR_CTRL, rd);
        check_value("notch_ctrl_set", longint'(32'h0501_0000), longint'(rd));
        send_random(16, 2);
        wait_drain();
        pulse_notch(6'b000010);
        m_bypass = 1'b0;
        wb_read(ADR_CTRL, rd);
        check_value("notch_ctrl_clear", longint'(32'h0500_0000), longint'(rd));
        test_name = "notch_resume";
        send_random(32, 2);
        wait_drain();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: rtl/biquad_top.sv
`timescale 1ns/10ps

module biquad_top import biquad_pkg::*; #(
    parameter int DATA_BITS = 16
) (
    input  logic                        clk_i,
    input  logic                        rst_i,
    // wishbone control port
    input  logic                        wb_cyc_i,
    input  logic                        wb_stb_i,
    input  logic                        wb_we_i,
    input  logic [WB_ADR_BITS-1:0]      wb_adr_i,
    input  logic [3:0]                  wb_sel_i,
    input  logic [WB_DAT_BITS-1:0]      wb_dat_i,
    output logic [WB_DAT_BITS-1:0]      wb_dat_o,
    output logic                        wb_ack_o,
    // sample stream
    input  logic signed [DATA_BITS-1:0] dat_i,
    input  logic                        dat_valid_i,
    output logic signed [DATA_BITS-1:0] dat_o,
    output logic                        dat_valid_o,
    // external notch request
    input  logic                        notch_update_i,
    input  logic [NOTCH_BITS-1:0]       notch_byp_i
);

    logic signed [STATE_BITS-1:0] w;
    logic signed [DATA_BITS-1:0]  x_dly;
    logic                         zero_valid;

    biquad_coeff_if i_coeff_if ();

    biquad_ctrl_regs i_ctrl_regs (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .wb_cyc_i       (wb_cyc_i),
        .wb_stb_i       (wb_stb_i),
        .wb_we_i        (wb_we_i),
        .wb_adr_i       (wb_adr_i),
        .wb_sel_i       (wb_sel_i),
        .wb_dat_i       (wb_dat_i),
        .wb_dat_o       (wb_dat_o),
        .wb_ack_o       (wb_ack_o),
        .notch_update_i (notch_update_i),
        .notch_byp_i    (notch_byp_i),
        .coeff          (i_coeff_if.ctrl)
    );

    biquad_zero_fir #(.DATA_BITS(DATA_BITS)) i_zero_fir (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .dat_i       (dat_i),
        .dat_valid_i (dat_valid_i),
        .coeff       (i_coeff_if.zero),
        .w_o         (w),
        .x_dly_o     (x_dly),
        .valid_o     (zero_valid)
    );

    biquad_pole_iir #(.DATA_BITS(DATA_BITS)) i_pole_iir (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .w_i         (w),
        .x_dly_i     (x_dly),
        .valid_i     (zero_valid),
        .coeff       (i_coeff_if.pole),
        .dat_o       (dat_o),
        .dat_valid_o (dat_valid_o)
    );

endmodule

// File: rtl/biquad_pole_iir.sv
`timescale 1ns/10ps

module biquad_pole_iir import biquad_pkg::*; #(
    parameter int DATA_BITS = 16
) (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic signed [STATE_BITS-1:0] w_i,
    input  logic signed [DATA_BITS-1:0]  x_dly_i,
    input  logic                         valid_i,
    biquad_coeff_if.pole                 coeff,
    output logic signed [DATA_BITS-1:0]  dat_o,
    output logic                         dat_valid_o
);

    // signed range of the output sample
    localparam logic signed [STATE_BITS-1:0] SAT_MAX =
        (STATE_ONE <<< (DATA_BITS - 1)) - STATE_ONE;
    localparam logic signed [STATE_BITS-1:0] SAT_MIN =
        -(STATE_ONE <<< (DATA_BITS - 1));

    // y[n-1] and y[n-2]
    logic signed [STATE_BITS-1:0] y1;
    logic signed [STATE_BITS-1:0] y2;

    logic signed [ACC_BITS-1:0]   fb;
    logic signed [STATE_BITS-1:0] y_next;
    logic signed [STATE_BITS-1:0] y_sat;

    // feedback sum, whole recursion fits in one cycle
    assign fb = ACC_BITS'(coeff.a1) * ACC_BITS'(y1) +
                ACC_BITS'(coeff.a2) * ACC_BITS'(y2);

    assign y_next = w_i + STATE_BITS'(fb >>> COEFF_FRAC);

    always_comb begin
        if (y_next > SAT_MAX) begin
            y_sat = SAT_MAX;
        end else if (y_next < SAT_MIN) begin
            y_sat = SAT_MIN;
        end else begin
            y_sat = y_next;
        end
    end

    // state keeps running in bypass so filtering resumes cleanly
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            y1 <= '0;
            y2 <= '0;
        end else if (valid_i) begin
            y1 <= y_next;
            y2 <= y1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            if (coeff.bypass) begin
                dat_o <= x_dly_i;
            end else begin
                dat_o <= DATA_BITS'(y_sat);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            dat_valid_o <= 1'b0;
        end else begin
            dat_valid_o <= valid_i;
        end
    end

endmodule

// File: rtl/biquad_zero_fir.sv
`timescale 1ns/10ps

module biquad_zero_fir import biquad_pkg::*; #(
    parameter int DATA_BITS = 16
) (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic signed [DATA_BITS-1:0]  dat_i,
    input  logic                         dat_valid_i,
    biquad_coeff_if.zero                 coeff,
    output logic signed [STATE_BITS-1:0] w_o,
    output logic signed [DATA_BITS-1:0]  x_dly_o,
    output logic                         valid_o
);

    // x[n-1] and x[n-2]
    logic signed [DATA_BITS-1:0] x1;
    logic signed [DATA_BITS-1:0] x2;

    logic signed [ACC_BITS-1:0]  p0_q;
    logic signed [ACC_BITS-1:0]  p1_q;
    logic signed [ACC_BITS-1:0]  p2_q;
    logic signed [DATA_BITS-1:0] x_q;
    logic                        valid_q;
    logic signed [ACC_BITS-1:0]  acc;

    // history only moves on a real sample
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            x1 <= '0;
            x2 <= '0;
        end else if (dat_valid_i) begin
            x1 <= dat_i;
            x2 <= x1;
        end
    end

    // stage 1, the three products
    always_ff @(posedge clk_i) begin
        p0_q <= ACC_BITS'(coeff.b0) * ACC_BITS'(dat_i);
        p1_q <= ACC_BITS'(coeff.b1) * ACC_BITS'(x1);
        p2_q <= ACC_BITS'(coeff.b2) * ACC_BITS'(x2);
        x_q  <= dat_i;
    end

    assign acc = p0_q + p1_q + p2_q;

    // stage 2, drop the Q14 fraction and wrap to state width
    always_ff @(posedge clk_i) begin
        w_o     <= STATE_BITS'(acc >>> COEFF_FRAC);
        x_dly_o <= x_q;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
            valid_o <= 1'b0;
        end else begin
            valid_q <= dat_valid_i;
            valid_o <= valid_q;
        end
    end

endmodule

// File: rtl/biquad_ctrl_regs.sv
`timescale 1ns/10ps

module biquad_ctrl_regs import biquad_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   wb_cyc_i,
    input  logic                   wb_stb_i,
    input  logic                   wb_we_i,
    input  logic [WB_ADR_BITS-1:0] wb_adr_i,
    input  logic [3:0]             wb_sel_i,
    input  logic [WB_DAT_BITS-1:0] wb_dat_i,
    output logic [WB_DAT_BITS-1:0] wb_dat_o,
    output logic                   wb_ack_o,
    input  logic                   notch_update_i,
    input  logic [NOTCH_BITS-1:0]  notch_byp_i,
    biquad_coeff_if.ctrl           coeff
);

    reg_addr_e                    adr;
    logic                         access;
    logic                         wr_en;
    logic                         wr_ctrl;
    logic signed [COEFF_BITS-1:0] b0_sh;
    logic signed [COEFF_BITS-1:0] b1_sh;
    logic signed [COEFF_BITS-1:0] b2_sh;
    logic signed [COEFF_BITS-1:0] a1_sh;
    logic signed [COEFF_BITS-1:0] a2_sh;
    logic [NOTCH_BITS-1:0]        notch_mask;
    logic                         notch_upd_q;
    logic [NOTCH_BITS-1:0]        notch_masked_q;
    logic [WB_DAT_BITS-1:0]       rd_data;

    // word aligned offset
    assign adr = reg_addr_e'({wb_adr_i[WB_ADR_BITS-1:2], 2'b00});

    // a request is served on the edge that raises ack
    assign access  = wb_cyc_i && wb_stb_i && !wb_ack_o;
    assign wr_en   = access && wb_we_i;
    assign wr_ctrl = wr_en && (adr == REG_CTRL);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= access;
        end
    end

    // shadow bank, only the low lane is used
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            b0_sh <= '0;
            b1_sh <= '0;
            b2_sh <= '0;
            a1_sh <= '0;
            a2_sh <= '0;
        end else if (wr_en && wb_sel_i[0]) begin
            case (adr)
                REG_B0:  b0_sh <= wb_dat_i[COEFF_BITS-1:0];
                REG_B1:  b1_sh <= wb_dat_i[COEFF_BITS-1:0];
                REG_B2:  b2_sh <= wb_dat_i[COEFF_BITS-1:0];
                REG_A1:  a1_sh <= wb_dat_i[COEFF_BITS-1:0];
                REG_A2:  a2_sh <= wb_dat_i[COEFF_BITS-1:0];
                default: ;
            endcase
        end
    end

    // whole active set switches on one edge
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            coeff.b0 <= '0;
            coeff.b1 <= '0;
            coeff.b2 <= '0;
            coeff.a1 <= '0;
            coeff.a2 <= '0;
        end else if (coeff.update) begin
            coeff.b0 <= b0_sh;
            coeff.b1 <= b1_sh;
            coeff.b2 <= b2_sh;
            coeff.a1 <= a1_sh;
            coeff.a2 <= a2_sh;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            coeff.update   <= 1'b0;
            notch_mask     <= '0;
            notch_upd_q    <= 1'b0;
            notch_masked_q <= '0;
            coeff.bypass   <= 1'b1;
        end else begin
            coeff.update <= wr_ctrl && wb_sel_i[CTRL_UPDATE_BIT / 8] &&
                            wb_dat_i[CTRL_UPDATE_BIT];
            if (wr_ctrl && wb_sel_i[CTRL_MASK_LSB / 8]) begin
                notch_mask <= wb_dat_i[CTRL_MASK_LSB +: NOTCH_BITS];
            end
            notch_upd_q    <= notch_update_i;
            notch_masked_q <= notch_byp_i & notch_mask;
            // notch request has priority over a register write
            if (notch_upd_q) begin
                coeff.bypass <= |notch_masked_q;
            end else if (wr_ctrl && wb_sel_i[CTRL_BYPASS_BIT / 8]) begin
                coeff.bypass <= wb_dat_i[CTRL_BYPASS_BIT];
            end
        end
    end

    always_comb begin
        rd_data = '0;
        case (adr)
            REG_CTRL: begin
                rd_data[CTRL_BYPASS_BIT]              = coeff.bypass;
                rd_data[CTRL_MASK_LSB +: NOTCH_BITS] = notch_mask;
            end
            // shadow values, sign extended
            REG_B0:  rd_data = WB_DAT_BITS'(b0_sh);
            REG_B1:  rd_data = WB_DAT_BITS'(b1_sh);
            REG_B2:  rd_data = WB_DAT_BITS'(b2_sh);
            REG_A1:  rd_data = WB_DAT_BITS'(a1_sh);
            REG_A2:  rd_data = WB_DAT_BITS'(a2_sh);
            default: rd_data = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (access && !wb_we_i) begin
            wb_dat_o <= rd_data;
        end
    end

endmodule

// File: rtl/biquad_coeff_if.sv
`timescale 1ns/10ps

interface biquad_coeff_if import biquad_pkg::*; ();

    // active coefficient set
    logic signed [COEFF_BITS-1:0] b0;
    logic signed [COEFF_BITS-1:0] b1;
    logic signed [COEFF_BITS-1:0] b2;
    logic signed [COEFF_BITS-1:0] a1;
    logic signed [COEFF_BITS-1:0] a2;

    // one-cycle pulse that copies the shadow bank
    logic update;

    logic bypass;

    modport ctrl (output b0, b1, b2, a1, a2, update, bypass);

    modport zero (input b0, b1, b2);

    modport pole (input a1, a2, bypass);

endinterface

// File: rtl/biquad_pkg.sv
package biquad_pkg;

    // coefficient format is Q4.14
    localparam int COEFF_BITS = 18;
    localparam int COEFF_FRAC = 14;

    // products and sums inside both sections
    localparam int ACC_BITS = 40;

    // zero-section result w and pole-section state y
    localparam int STATE_BITS = 24;

    // wishbone target widths
    localparam int WB_ADR_BITS = 7;
    localparam int WB_DAT_BITS = 32;

    localparam int NOTCH_BITS = 6;

    // bit fields of REG_CTRL
    localparam int CTRL_UPDATE_BIT = 0;
    localparam int CTRL_BYPASS_BIT = 16;
    localparam int CTRL_MASK_LSB   = 24;

    // unit value at state width, the clamp limits are built from it
    localparam logic signed [STATE_BITS-1:0] STATE_ONE = 1;

    // byte offsets, anything else reads zero
    typedef enum logic [WB_ADR_BITS-1:0] {
        REG_CTRL = 7'h00,
        REG_B0   = 7'h04,
        REG_B1   = 7'h08,
        REG_B2   = 7'h0C,
        REG_A1   = 7'h10,
        REG_A2   = 7'h14
    } reg_addr_e;

endpackage
